// File: exu_pkg.sv
// execute cluster definitions
package exu_pkg;

  localparam int XLEN  = 64;
  localparam int REG_W = 5;
  localparam int OP_W  = 5;

  // alu operation codes
  typedef enum logic [OP_W-1:0] {
    alu_add    = 5'd0,
    alu_sub    = 5'd1,
    alu_slt    = 5'd2,
    alu_sltu   = 5'd3,
    alu_xor    = 5'd4,
    alu_and    = 5'd5,
    alu_or     = 5'd6,
    alu_sll    = 5'd7,
    alu_srl    = 5'd8,
    alu_sra    = 5'd9,
    alu_mul    = 5'd10,
    alu_div    = 5'd11,
    alu_divu   = 5'd12,
    alu_rem    = 5'd13,
    alu_remu   = 5'd14,
    alu_copy   = 5'd15,
    alu_mulh   = 5'd25,
    alu_mulhsu = 5'd26,
    alu_mulhu  = 5'd27
  } alu_op_e;

  // operand a source
  typedef enum logic {
    a_rs1 = 1'b0,
    a_pc  = 1'b1
  } a_sel_e;

  // operand b source, code 3 unused
  typedef enum logic [1:0] {
    b_rs2  = 2'd0,
    b_imm  = 2'd1,
    b_four = 2'd2
  } b_sel_e;

  // decoded instruction as it enters the cluster
  typedef struct packed {
    logic             valid;
    alu_op_e          op;
    a_sel_e           a_sel;
    b_sel_e           b_sel;
    logic             word;
    logic [REG_W-1:0] rd;
    logic [XLEN-1:0]  rs1_val;
    logic [XLEN-1:0]  rs2_val;
    logic [XLEN-1:0]  imm;
    logic [XLEN-1:0]  pc;
  } exu_op_t;

  // operands after selection
  typedef struct packed {
    logic             valid;
    alu_op_e          op;
    logic             word;
    logic [REG_W-1:0] rd;
    logic [XLEN-1:0]  src_a;
    logic [XLEN-1:0]  src_b;
    logic [XLEN-1:0]  imm;
  } exu_lane_in_t;

  typedef struct packed {
    logic             valid;
    logic [REG_W-1:0] rd;
    logic [XLEN-1:0]  result;
    logic             zero;
    logic             less;
  } exu_lane_out_t;

  typedef struct packed {
    logic             valid;
    logic [REG_W-1:0] rd;
    logic [XLEN-1:0]  data;
  } exu_wb_t;

endpackage

// File: exu_issue.sv
// execute issue stage
module exu_issue #(
  parameter int NUM_LANES = 2
) (
  input  logic                                  i_clk,
  input  logic                                  i_reset,
  input  exu_pkg::exu_op_t      [NUM_LANES-1:0] i_ops,
  output exu_pkg::exu_lane_in_t [NUM_LANES-1:0] o_lane_in
);

  localparam int XLEN = exu_pkg::XLEN;

  exu_pkg::exu_lane_in_t [NUM_LANES-1:0] lane_d;

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_slot
    logic [XLEN-1:0] rs1_cut;
    logic [XLEN-1:0] rs2_cut;
    logic [XLEN-1:0] imm_cut;
    logic [XLEN-1:0] src_a;
    logic [XLEN-1:0] src_b;

    // word forms keep only the low half, zero extended
    assign rs1_cut = i_ops[i].word ? {{(XLEN-32){1'b0}}, i_ops[i].rs1_val[31:0]}
                                   : i_ops[i].rs1_val;
    assign rs2_cut = i_ops[i].word ? {{(XLEN-32){1'b0}}, i_ops[i].rs2_val[31:0]}
                                   : i_ops[i].rs2_val;
    assign imm_cut = i_ops[i].word ? {{(XLEN-32){1'b0}}, i_ops[i].imm[31:0]}
                                   : i_ops[i].imm;

    // pc is never cut
    assign src_a = (i_ops[i].a_sel == exu_pkg::a_pc) ? i_ops[i].pc : rs1_cut;

    always_comb begin
      case (i_ops[i].b_sel)
        exu_pkg::b_rs2:  src_b = rs2_cut;
        exu_pkg::b_imm:  src_b = imm_cut;
        // link address offset
        exu_pkg::b_four: src_b = XLEN'(4);
        default:         src_b = '0;
      endcase
    end

    // copy-imm takes the raw immediate
    assign lane_d[i] = '{
      valid: i_ops[i].valid,
      op:    i_ops[i].op,
      word:  i_ops[i].word,
      rd:    i_ops[i].rd,
      src_a: src_a,
      src_b: src_b,
      imm:   i_ops[i].imm
    };

    a_b_sel_legal: assert property (@(posedge i_clk) disable iff (i_reset)
      i_ops[i].valid |-> (i_ops[i].b_sel != 2'd3));
  end

  // only the valid bits see reset
  always_ff @(posedge i_clk) begin
    o_lane_in <= lane_d;
    if (i_reset) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        o_lane_in[i].valid <= 1'b0;
      end
    end
  end

endmodule

// File: exu_alu_lane.sv
// rv64 alu lane
module exu_alu_lane (
  input  logic                   i_clk,
  input  logic                   i_reset,
  input  exu_pkg::exu_lane_in_t  i_in,
  output exu_pkg::exu_lane_out_t o_out
);

  localparam int XLEN = exu_pkg::XLEN;

  logic [XLEN-1:0]   a;
  logic [XLEN-1:0]   b;
  logic              word;

  // compare path
  logic [XLEN-1:0]   diff;
  logic              borrow;
  logic              overflow;
  logic              signed_less;
  logic              unsigned_less;
  logic              less;

  // shifts
  logic [5:0]        shamt;
  logic [XLEN-1:0]   a_zx;
  logic [XLEN-1:0]   sll_res;
  logic [XLEN-1:0]   srl_res;
  logic signed [XLEN-1:0] sra_d;
  logic signed [31:0]     sra_w;
  logic [XLEN-1:0]   sra_res;

  // multiply
  logic [2*XLEN-1:0] prod_ss;
  logic [2*XLEN-1:0] prod_su;
  logic [2*XLEN-1:0] prod_uu;

  // divide
  logic [XLEN-1:0]   div_a;
  logic [XLEN-1:0]   div_b;
  logic [XLEN-1:0]   divu_a;
  logic [XLEN-1:0]   divu_b;
  logic [XLEN-1:0]   min_val;
  logic              div_zero;
  logic              divu_zero;
  logic              div_ovf;
  logic signed [XLEN-1:0] sdiv_q;
  logic signed [XLEN-1:0] sdiv_r;
  logic [XLEN-1:0]   quot_s;
  logic [XLEN-1:0]   rem_s;
  logic [XLEN-1:0]   quot_u;
  logic [XLEN-1:0]   rem_u;

  logic [XLEN-1:0]   result;
  logic [XLEN-1:0]   result_cut;

  assign a    = i_in.src_a;
  assign b    = i_in.src_b;
  assign word = i_in.word;

  // one subtractor feeds sub, slt/sltu and both flags
  assign {borrow, diff} = {1'b0, a} - {1'b0, b};
  assign overflow       = (a[XLEN-1] ^ b[XLEN-1]) & (diff[XLEN-1] ^ a[XLEN-1]);
  assign signed_less    = diff[XLEN-1] ^ overflow;
  assign unsigned_less  = borrow;

  always_comb begin
    case (i_in.op)
      exu_pkg::alu_slt:  less = signed_less;
      exu_pkg::alu_sltu: less = unsigned_less;
      default:           less = 1'b0;
    endcase
  end

  assign shamt   = word ? {1'b0, b[4:0]} : b[5:0];
  assign a_zx    = word ? {{(XLEN-32){1'b0}}, a[31:0]} : a;
  assign sll_res = a << shamt;
  assign srl_res = a_zx >> shamt;
  assign sra_d   = $signed(a) >>> shamt;
  assign sra_w   = $signed(a[31:0]) >>> b[4:0];
  assign sra_res = word ? {{(XLEN-32){sra_w[31]}}, sra_w} : sra_d;

  // low 128 bits of each product are exact after extension
  assign prod_ss = {{XLEN{a[XLEN-1]}}, a} * {{XLEN{b[XLEN-1]}}, b};
  assign prod_su = {{XLEN{a[XLEN-1]}}, a} * {{XLEN{1'b0}}, b};
  assign prod_uu = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};

  // word divides see 32-bit operands
  assign div_a  = word ? {{(XLEN-32){a[31]}}, a[31:0]} : a;
  assign div_b  = word ? {{(XLEN-32){b[31]}}, b[31:0]} : b;
  assign divu_a = a_zx;
  assign divu_b = word ? {{(XLEN-32){1'b0}}, b[31:0]} : b;

  assign min_val   = word ? {{(XLEN-31){1'b1}}, 31'b0} : {1'b1, {(XLEN-1){1'b0}}};
  assign div_zero  = (div_b == '0);
  assign divu_zero = (divu_b == '0);
  assign div_ovf   = (div_a == min_val) && (div_b == '1);

  assign sdiv_q = $signed(div_a) / $signed(div_b);
  assign sdiv_r = $signed(div_a) % $signed(div_b);

  // riscv corner cases for zero divisor and signed overflow
  assign quot_s = div_zero ? '1 : (div_ovf ? div_a : sdiv_q);
  assign rem_s  = div_zero ? div_a : (div_ovf ? '0 : sdiv_r);
  assign quot_u = divu_zero ? '1 : (divu_a / divu_b);
  assign rem_u  = divu_zero ? divu_a : (divu_a % divu_b);

  always_comb begin
    case (i_in.op)
      exu_pkg::alu_add:    result = a + b;
      exu_pkg::alu_sub:    result = diff;
      exu_pkg::alu_slt:    result = XLEN'(signed_less);
      exu_pkg::alu_sltu:   result = XLEN'(unsigned_less);
      exu_pkg::alu_xor:    result = a ^ b;
      exu_pkg::alu_and:    result = a & b;
      exu_pkg::alu_or:     result = a | b;
      exu_pkg::alu_sll:    result = sll_res;
      exu_pkg::alu_srl:    result = srl_res;
      exu_pkg::alu_sra:    result = sra_res;
      exu_pkg::alu_mul:    result = prod_uu[XLEN-1:0];
      exu_pkg::alu_mulh:   result = prod_ss[2*XLEN-1:XLEN];
      exu_pkg::alu_mulhsu: result = prod_su[2*XLEN-1:XLEN];
      exu_pkg::alu_mulhu:  result = prod_uu[2*XLEN-1:XLEN];
      exu_pkg::alu_div:    result = quot_s;
      exu_pkg::alu_divu:   result = quot_u;
      exu_pkg::alu_rem:    result = rem_s;
      exu_pkg::alu_remu:   result = rem_u;
      exu_pkg::alu_copy:   result = i_in.imm;
      default:             result = '0;
    endcase
  end

  // word results are sign extended from bit 31
  assign result_cut = word ? {{(XLEN-32){result[31]}}, result[31:0]} : result;

  always_ff @(posedge i_clk) begin
    o_out.valid  <= i_in.valid;
    o_out.rd     <= i_in.rd;
    o_out.result <= result_cut;
    o_out.zero   <= (diff == '0);
    o_out.less   <= less;
    if (i_reset) begin
      o_out.valid <= 1'b0;
    end
  end

  a_op_defined: assert property (@(posedge i_clk) disable iff (i_reset)
    i_in.valid |-> (i_in.op inside {[5'd0:5'd15], [5'd25:5'd27]}));

endmodule

// File: exu_writeback.sv
// execute writeback stage
module exu_writeback #(
  parameter int NUM_LANES = 2
) (
  input  logic                                   i_clk,
  input  logic                                   i_reset,
  input  exu_pkg::exu_lane_out_t [NUM_LANES-1:0] i_lane_out,
  output exu_pkg::exu_wb_t       [NUM_LANES-1:0] o_wb
);

  logic [NUM_LANES-1:0] keep;

  // lane 0 is oldest, so a younger lane with the same rd wins
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      keep[i] = i_lane_out[i].valid && (i_lane_out[i].rd != '0);
      for (int j = i + 1; j < NUM_LANES; j++) begin
        if (i_lane_out[j].valid && (i_lane_out[j].rd == i_lane_out[i].rd)) begin
          keep[i] = 1'b0;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    for (int i = 0; i < NUM_LANES; i++) begin
      o_wb[i].valid <= keep[i];
      o_wb[i].rd    <= i_lane_out[i].rd;
      o_wb[i].data  <= i_lane_out[i].result;
    end
    if (i_reset) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        o_wb[i].valid <= 1'b0;
      end
    end
  end

  // x0 writes must have been filtered upstream of the register
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_chk
    a_no_x0_write: assert property (@(posedge i_clk) disable iff (i_reset)
      o_wb[i].valid |-> (o_wb[i].rd != '0));
  end

endmodule

// File: exu_top.sv
// two-wide rv64 execute cluster
module exu_top #(
  parameter int NUM_LANES = 2
) (
  input  logic                             i_clk,
  input  logic                             i_reset,
  input  exu_pkg::exu_op_t [NUM_LANES-1:0] i_ops,
  output exu_pkg::exu_wb_t [NUM_LANES-1:0] o_wb,
  output logic             [NUM_LANES-1:0] o_zero,
  output logic             [NUM_LANES-1:0] o_less
);

  exu_pkg::exu_lane_in_t  [NUM_LANES-1:0] lane_in;
  exu_pkg::exu_lane_out_t [NUM_LANES-1:0] lane_out;

  exu_issue #(
    .NUM_LANES (NUM_LANES)
  ) u_issue (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_ops     (i_ops),
    .o_lane_in (lane_in)
  );

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    exu_alu_lane u_lane (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_in    (lane_in[i]),
      .o_out   (lane_out[i])
    );

    // flags leave with the lane output, one stage before writeback
    assign o_zero[i] = lane_out[i].zero;
    assign o_less[i] = lane_out[i].less;
  end

  exu_writeback #(
    .NUM_LANES (NUM_LANES)
  ) u_wb (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_lane_out (lane_out),
    .o_wb       (o_wb)
  );

endmodule

// File: exu_tb.sv
// execute cluster testbench
module exu_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int  NUM_LANES  = 2;
  localparam int  NUM_VEC    = 20;
  // each line holds five words per lane then the expect word and both data words
  localparam int  WORDS      = 13;
  localparam int  IDLE_LEAD  = 2;
  localparam int  IDLE_TAIL  = 4;
  localparam int  RESET_CYC  = 16;
  localparam real CLK_PERIOD = 20.0;

  logic                             clk;
  logic                             reset;
  exu_pkg::exu_op_t [NUM_LANES-1:0] ops;
  exu_pkg::exu_wb_t [NUM_LANES-1:0] wb;
  logic             [NUM_LANES-1:0] zero_flags;
  logic             [NUM_LANES-1:0] less_flags;

  logic [63:0] vec_mem [0:NUM_VEC*WORDS-1];

  // vector index per issued bundle with -1 for idle
  int flag_q[$];
  int wb_q[$];
  int errors;
  int checks;

  exu_top #(
    .NUM_LANES (NUM_LANES)
  ) u_dut (
    .i_clk   (clk),
    .i_reset (reset),
    .i_ops   (ops),
    .o_wb    (wb),
    .o_zero  (zero_flags),
    .o_less  (less_flags)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // control word hex digits are valid, op (2), a_sel, b_sel, word and rd (2)
  function automatic exu_pkg::exu_op_t lane_op(input int base);
    exu_pkg::exu_op_t op;
    logic [63:0]      ctl;
    ctl        = vec_mem[base];
    op.valid   = ctl[28];
    op.op      = exu_pkg::alu_op_e'(ctl[24:20]);
    op.a_sel   = exu_pkg::a_sel_e'(ctl[16]);
    op.b_sel   = exu_pkg::b_sel_e'(ctl[13:12]);
    op.word    = ctl[8];
    op.rd      = ctl[4:0];
    op.rs1_val = vec_mem[base+1];
    op.rs2_val = vec_mem[base+2];
    op.imm     = vec_mem[base+3];
    op.pc      = vec_mem[base+4];
    return op;
  endfunction

  // each lane field holds valid [16], rd [15:8], zero [4] and less [0]
  function automatic logic [19:0] lane_expect(input int v, input int l);
    logic [63:0] exp_word;
    exp_word = vec_mem[v*WORDS + 10] >> ((NUM_LANES - 1 - l) * 20);
    return exp_word[19:0];
  endfunction

  task automatic apply_bundle(input int v);
    for (int l = 0; l < NUM_LANES; l++) begin
      if (v < 0) begin
        ops[l] = '0;
      end else begin
        ops[l] = lane_op(v*WORDS + l*5);
      end
    end
  endtask

  task automatic check_flags(input int v);
    logic [19:0] e;
    for (int l = 0; l < NUM_LANES; l++) begin
      e = lane_expect(v, l);
      // flags only mean something for a valid slot
      if (vec_mem[v*WORDS + l*5][28]) begin
        checks += 2;
        assert (zero_flags[l] === e[4]) else begin
          $display("error at %0d ns: vector %0d lane %0d zero got %b expected %b",
                   $time, v, l, zero_flags[l], e[4]);
          errors++;
        end
        assert (less_flags[l] === e[0]) else begin
          $display("error at %0d ns: vector %0d lane %0d less got %b expected %b",
                   $time, v, l, less_flags[l], e[0]);
          errors++;
        end
      end
    end
  endtask

  task automatic check_wb(input int v);
    logic [19:0] e;
    logic        exp_valid;
    logic [63:0] exp_data;
    for (int l = 0; l < NUM_LANES; l++) begin
      e         = '0;
      exp_valid = 1'b0;
      exp_data  = '0;
      if (v >= 0) begin
        e         = lane_expect(v, l);
        exp_valid = e[16];
        exp_data  = vec_mem[v*WORDS + 11 + l];
      end
      checks++;
      assert (wb[l].valid === exp_valid) else begin
        $display("error at %0d ns: vector %0d lane %0d wb valid got %b expected %b",
                 $time, v, l, wb[l].valid, exp_valid);
        errors++;
      end
      if (exp_valid) begin
        checks += 2;
        assert (wb[l].rd === e[12:8]) else begin
          $display("error at %0d ns: vector %0d lane %0d wb rd got %0d expected %0d",
                   $time, v, l, wb[l].rd, e[12:8]);
          errors++;
        end
        assert (wb[l].data === exp_data) else begin
          $display("error at %0d ns: vector %0d lane %0d wb data got %h expected %h",
                   $time, v, l, wb[l].data, exp_data);
          errors++;
        end
      end
    end
  endtask

  // flags trail the drive by two cycles and writeback by three
  task automatic check_outputs();
    int v;
    if (flag_q.size() == 2) begin
      v = flag_q.pop_front();
      if (v >= 0) begin
        check_flags(v);
      end
    end
    if (wb_q.size() == 3) begin
      v = wb_q.pop_front();
      check_wb(v);
    end else begin
      // nothing has reached writeback yet
      check_wb(-1);
    end
  endtask

  initial begin
    int total;
    int v;
    errors = 0;
    checks = 0;
    reset  = 1'b1;
    ops    = '0;
    $readmemh("exu_vectors.txt", vec_mem);
    if ($isunknown(vec_mem[0]) || $isunknown(vec_mem[NUM_VEC*WORDS-1])) begin
      $display("could not read a complete exu_vectors.txt, no vectors applied");
      errors++;
    end else begin
      repeat (RESET_CYC) @(posedge clk);
      #2;
      reset = 1'b0;
      total = IDLE_LEAD + NUM_VEC + IDLE_TAIL;
      for (int c = 0; c < total; c++) begin
        @(posedge clk);
        #2;
        check_outputs();
        v = c - IDLE_LEAD;
        if (v >= NUM_VEC) begin
          v = -1;
        end
        apply_bundle(v);
        flag_q.push_back(v);
        wb_q.push_back(v);
      end
    end
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // watchdog scaled from reset, vector count and drain
  initial begin
    #((RESET_CYC + NUM_VEC + 10) * CLK_PERIOD * 4);
    $display("timeout: the run did not finish before all vectors were applied");
    $display("Testbench failed");
    $finish;
  end

endmodule

// File: exu_vectors.txt
// ctl0 rs1 rs2 imm pc | ctl1 rs1 rs2 imm pc | expect data0 data1
// ctl: valid op(2) a_sel b_sel word rd(2); expect per lane: valid rd(2) zero less
10001001 10 0 5 0 10012002 0 0 0 1000 1010010200 15 1004
10100003 5 7 0 0 10400004 1234 1234 0 0 1030010410 fffffffffffffffe 0
10500005 f0f0 ff00 0 0 10601006 f 0 f0 0 1050010600 f000 ff
10700007 1 3f 0 0 10900008 8000000000000000 4 0 0 1070010800 8000000000000000 f800000000000000
10800109 ffffffff80000000 24 0 0 1090010a 80000000 4 0 0 1090010a00 8000000 fffffffff8000000
1000010b 7fffffff 1 0 0 10f0100c 0 0 123456789abcdef0 0 10b0010c00 ffffffff80000000 123456789abcdef0
1020000d 8000000000000000 1 0 0 1030000e 8000000000000000 1 0 0 10d0110e00 1 0
1020000f 7fffffffffffffff ffffffffffffffff 0 0 10300010 1 ffffffffffffffff 0 0 10f0011001 0 1
10200011 fffffffffffffffb fffffffffffffffb 0 0 10201012 fffffffffffffffb 0 3 0 1111011201 0 1
10a00013 ffffffffffffffff 3 0 0 11900014 ffffffffffffffff 3 0 0 1130011400 fffffffffffffffd ffffffffffffffff
11a00015 ffffffffffffffff ffffffffffffffff 0 0 11b00016 ffffffffffffffff ffffffffffffffff 0 0 1151011610 ffffffffffffffff fffffffffffffffe
10b00017 fffffffffffffff9 2 0 0 10d00018 fffffffffffffff9 2 0 0 1170011800 fffffffffffffffd ffffffffffffffff
10b00019 1234 0 0 0 10d0001a 1234 0 0 0 1190011a00 ffffffffffffffff 1234
10b0001b 8000000000000000 ffffffffffffffff 0 0 10d0001c 8000000000000000 ffffffffffffffff 0 0 11b0011c00 8000000000000000 0
10c0001d ffffffffffffffff 2 0 0 10e0001e 64 0 0 0 11d0011e00 7fffffffffffffff 64
10b0011f 80000000 ffffffff 0 0 10e00101 180000000 100000000 0 0 11f0010100 ffffffff80000000 ffffffff80000000
10000000 1 1 0 0 10000005 2 3 0 0 0001010500 0 5
10000006 1 1 0 0 10100006 9 4 0 0 0061010600 2 5
10000007 3 4 0 0 00000007 ff 0 0 0 1070000700 7 0
10300000 0 1 0 0 00000000 0 0 0 0 0000100000 0 0

// File: all.f
exu_pkg.sv
exu_issue.sv
exu_alu_lane.sv
exu_writeback.sv
exu_top.sv
exu_tb.sv
